// ==== verilog/status_pkg.sv ====
// shared widths and types for the status packet tree
// packet is one header byte {chan, seq} then a 24-bit word, LSB first
// FIFO half-full threshold must leave room for one whole packet
package status_pkg;

    localparam int FIFO_DEPTH_LOG2 = 4;                     // 16 entries per input FIFO
    localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
    localparam int FIFO_HALF       = FIFO_DEPTH / 2;        // stop accepting at this fill
    localparam int NUM_CHANNELS    = 4;                     // sources at the top level
    localparam int PACKET_BYTES    = 4;                     // header + 3 data bytes

    typedef logic [7:0]  status_byte_t;                     // one link byte
    typedef logic [23:0] status_word_t;                     // payload of one packet
    typedef logic [1:0]  chan_id_t;                         // source channel number
    typedef logic [5:0]  seq_t;                             // per channel, wraps

    // sender side of a link, start comes back separately
    typedef struct packed {
        status_byte_t db;                                   // data byte
        logic         rq;                                   // low on the last byte
    } status_link_t;

    // one FIFO slot, last marks the packet end
    typedef struct packed {
        logic         last;
        status_byte_t db;
    } fifo_entry_t;

endpackage

// ==== verilog/status_fifo.sv ====
// first-word-fallthrough FIFO, data_out is the head without a register stage
// writes to a full FIFO and reads from an empty one are ignored
// half_full is registered and set at FIFO_HALF or more entries
module status_fifo (
    input  logic                     rst,       // clock
    input  logic                     clk,       // async reset, active high
    input  logic                     we,
    input  logic                     re,
    input  status_pkg::fifo_entry_t  data_in,
    output status_pkg::fifo_entry_t  data_out,
    output logic                     nempty,
    output logic                     half_full
);
    import status_pkg::*;

    typedef logic [FIFO_DEPTH_LOG2-1:0] ptr_t;
    typedef logic [FIFO_DEPTH_LOG2:0]   cnt_t;      // one extra bit to hold FIFO_DEPTH

    fifo_entry_t mem [FIFO_DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        count;
    cnt_t        count_next;
    logic        full;
    logic        do_wr;
    logic        do_rd;

    assign full   = (count == cnt_t'(FIFO_DEPTH));
    assign nempty = (count != '0);
    assign do_wr  = we && !full;
    assign do_rd  = re && nempty;

    assign data_out = mem[rd_ptr];                  // fallthrough head

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            half_full <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count_next;
            half_full <= (count_next >= cnt_t'(FIFO_HALF)); // tracks count exactly
        end
    end

    // storage
    always_ff @(posedge rst) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

// ==== verilog/status_router2.sv ====
// 2:1 packet router, each input buffered in its own FIFO
// start signals are combinational and last one cycle
// packets leave whole, round robin when both FIFOs hold data
module status_router2 (
    input  logic                      rst,        // clock
    input  logic                      clk,        // async reset, active high
    input  status_pkg::status_link_t  link_in0,
    output logic                      start_in0,  // first byte accepted
    input  status_pkg::status_link_t  link_in1,
    output logic                      start_in1,
    output status_pkg::status_link_t  link_out,
    input  logic                      start_out   // from downstream, one cycle
);
    import status_pkg::*;

    logic [1:0]  rq_in;
    logic [1:0]  start_rcv;
    logic [1:0]  rcv_rest;          // receiving bytes after the first
    logic [1:0]  fifo_we;
    logic [1:0]  fifo_re;
    logic [1:0]  fifo_nempty;
    logic [1:0]  fifo_half;
    fifo_entry_t fifo_din [2];
    fifo_entry_t fifo_dout [2];
    logic        snd_rest;          // forwarding bytes after the first
    logic        cur_chn;           // channel being forwarded
    logic        next_chn;          // round robin pointer
    logic        sel_chn;           // pick for the next packet
    logic        out_chn;
    logic        snd_last;
    logic        rd_en;

    // input side
    assign rq_in     = {link_in1.rq, link_in0.rq};
    assign start_rcv = rq_in & ~rcv_rest & ~fifo_half;  // skip half-full inputs
    assign start_in0 = start_rcv[0];
    assign start_in1 = start_rcv[1];
    assign fifo_we   = start_rcv | rcv_rest;

    // rq low after the first byte marks the end
    assign fifo_din[0] = '{last: rcv_rest[0] & ~rq_in[0], db: link_in0.db};
    assign fifo_din[1] = '{last: rcv_rest[1] & ~rq_in[1], db: link_in1.db};

    // output side
    assign sel_chn  = (&fifo_nempty) ? next_chn : fifo_nempty[1];
    assign out_chn  = snd_rest ? cur_chn : sel_chn;   // mux set up before start_out
    assign snd_last = fifo_dout[cur_chn].last;
    assign rd_en    = start_out || snd_rest;
    assign fifo_re  = {rd_en & out_chn, rd_en & ~out_chn};

    assign link_out.db = fifo_dout[out_chn].db;
    assign link_out.rq = snd_rest ? ~snd_last : |fifo_nempty;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rcv_rest <= 2'b00;
            snd_rest <= 1'b0;
            cur_chn  <= 1'b0;
            next_chn <= 1'b0;
        end else begin
            rcv_rest <= (rcv_rest & rq_in) | start_rcv;  // drops after the last byte
            if (snd_rest) begin
                snd_rest <= ~snd_last;
            end else begin
                snd_rest <= start_out;
            end
            if (start_out && !snd_rest) begin
                cur_chn  <= sel_chn;
                next_chn <= ~sel_chn;               // other input gets the next turn
            end
        end
    end

    status_fifo fifo_in0_i (
        .rst       (rst),
        .clk       (clk),
        .we        (fifo_we[0]),
        .re        (fifo_re[0]),
        .data_in   (fifo_din[0]),
        .data_out  (fifo_dout[0]),
        .nempty    (fifo_nempty[0]),
        .half_full (fifo_half[0])
    );

    status_fifo fifo_in1_i (
        .rst       (rst),
        .clk       (clk),
        .we        (fifo_we[1]),
        .re        (fifo_re[1]),
        .data_in   (fifo_din[1]),
        .data_out  (fifo_dout[1]),
        .nempty    (fifo_nempty[1]),
        .half_full (fifo_half[1])
    );

endmodule

// ==== verilog/status_generator.sv ====
// sends one four-byte status packet per trigger
// a send during a transfer waits as pending, newer sends overwrite it
// the word is taken when start arrives, not when send is seen
module status_generator #(
    parameter status_pkg::chan_id_t CHANNEL_ID = '0
) (
    input  logic                      rst,      // clock
    input  logic                      clk,      // async reset, active high
    input  logic                      send,     // one-cycle trigger
    input  status_pkg::status_word_t  status,
    output status_pkg::status_link_t  link,
    input  logic                      start     // from router, one cycle
);
    import status_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_request,     // header on db, waiting for start
        st_stream       // data bytes, LSB first
    } gen_state_t;

    typedef logic [$clog2(PACKET_BYTES)-1:0] byte_idx_t;

    gen_state_t   state;
    status_word_t pend_word;    // newest captured value
    logic         pend_valid;
    status_word_t tx_word;      // shifts right one byte per cycle
    seq_t         seq;
    byte_idx_t    byte_cnt;     // data byte index in stream
    logic         take;
    logic         last_byte;

    assign take      = (state == st_request) && start;
    assign last_byte = (state == st_stream) && (byte_cnt == byte_idx_t'(PACKET_BYTES - 2));

    always_comb begin
        link.rq = (state == st_request) || ((state == st_stream) && !last_byte);
        if (state == st_stream) begin
            link.db = tx_word[7:0];
        end else begin
            link.db = {CHANNEL_ID, seq};            // header
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state      <= st_idle;
            pend_valid <= 1'b0;
            seq        <= '0;
            byte_cnt   <= '0;
        end else begin
            if (send) begin
                pend_valid <= 1'b1;
            end else if (take) begin
                pend_valid <= 1'b0;                 // word now in flight
            end
            case (state)
                st_idle: begin
                    if (send || pend_valid) begin
                        state <= st_request;        // rq next cycle
                    end
                end
                st_request: begin
                    if (start) begin
                        state    <= st_stream;
                        byte_cnt <= '0;
                    end
                end
                st_stream: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (last_byte) begin
                        seq <= seq + 1'b1;          // wraps
                        if (send || pend_valid) begin
                            state <= st_request;    // back to back
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload
    always_ff @(posedge rst) begin
        if (send) begin
            pend_word <= status;
        end
        if (take) begin
            tx_word <= pend_word;                   // send on this edge waits for next packet
        end else if (state == st_stream) begin
            tx_word <= tx_word >> 8;
        end
    end

endmodule

// ==== verilog/status_top.sv ====
// four status sources merged onto one link through a 4:1 router tree
// minimum latency from a generator start to rq on link_out is 2 cycles
// start_out is combinational and high for one cycle per packet
module status_top (
    input  logic                                     rst,        // clock
    input  logic                                     clk,        // async reset, active high
    input  logic [status_pkg::NUM_CHANNELS-1:0]      send,
    input  status_pkg::status_word_t                 status [status_pkg::NUM_CHANNELS],
    output status_pkg::status_link_t                 link_out,
    input  logic                                     start_out
);
    import status_pkg::*;

    status_link_t            gen_link [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] gen_start;
    status_link_t            link_a;     // channels 0 and 1
    logic                    start_a;
    status_link_t            link_b;     // channels 2 and 3
    logic                    start_b;

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gen_ch
        status_generator #(
            .CHANNEL_ID (chan_id_t'(i))
        ) generator_i (
            .rst    (rst),
            .clk    (clk),
            .send   (send[i]),
            .status (status[i]),
            .link   (gen_link[i]),
            .start  (gen_start[i])
        );
    end

    // first level
    status_router2 router_a (
        .rst       (rst),
        .clk       (clk),
        .link_in0  (gen_link[0]),
        .start_in0 (gen_start[0]),
        .link_in1  (gen_link[1]),
        .start_in1 (gen_start[1]),
        .link_out  (link_a),
        .start_out (start_a)
    );

    status_router2 router_b (
        .rst       (rst),
        .clk       (clk),
        .link_in0  (gen_link[2]),
        .start_in0 (gen_start[2]),
        .link_in1  (gen_link[3]),
        .start_in1 (gen_start[3]),
        .link_out  (link_b),
        .start_out (start_b)
    );

    // second level
    status_router2 router_root (
        .rst       (rst),
        .clk       (clk),
        .link_in0  (link_a),
        .start_in0 (start_a),
        .link_in1  (link_b),
        .start_in1 (start_b),
        .link_out  (link_out),
        .start_out (start_out)
    );

endmodule

// ==== bench/status_top_tb.sv ====
// directed tests for the 4:1 status tree, a consumer answers rq with start
// expected packets come from a per-channel model of the sends
// rst is the clock and clk the reset, as on the DUT ports
module status_top_tb;
    import status_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int BUDGET_IDLE   = 60;
    localparam int BUDGET_SINGLE = 400;
    localparam int BUDGET_ALL    = 200;
    localparam int BUDGET_RR     = 600;
    localparam int BUDGET_BP     = 800;
    localparam int MARGIN        = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + BUDGET_IDLE + BUDGET_SINGLE + BUDGET_ALL
                                   + BUDGET_RR + BUDGET_BP + MARGIN;
    localparam int LOG_DEPTH     = 16;                      // sends kept per channel

    logic                    rst = 1'b0;                    // clock
    logic                    clk = 1'b1;                    // reset, high from time 0
    logic [NUM_CHANNELS-1:0] send;
    status_word_t            status [NUM_CHANNELS];
    status_link_t            link_out;
    status_link_t            link_smp = '0;                 // link_out at mid cycle
    logic                    start_out = 1'b0;              // driven by the consumer

    logic                    hold_start;                    // back-pressure switch
    int                      start_delay;                   // cycles from rq to start
    int                      wait_cnt = 0;
    logic                    receiving = 1'b0;
    int                      rx_len = 0;
    logic [31:0]             rx_pkt;                        // {word, header}
    logic [31:0]             rx_q [$];                      // finished packets

    logic [31:0]             lfsr = 32'ha9e1_12ae;
    status_word_t            last_word [NUM_CHANNELS];      // newest value sent
    seq_t                    exp_seq [NUM_CHANNELS];
    status_word_t            sent_words [NUM_CHANNELS][LOG_DEPTH];
    int                      sent_cnt [NUM_CHANNELS];
    string                   cur_test;
    int                      tests_run = 0;
    int                      checks = 0;
    int                      errors = 0;
    int                      test_err_start = 0;

    status_top status_top_i (
        .rst       (rst),
        .clk       (clk),
        .send      (send),
        .status    (status),
        .link_out  (link_out),
        .start_out (start_out)
    );

    always #(CLK_PERIOD / 2) rst = ~rst;

    // sampled away from the active edge
    always @(negedge rst) begin
        link_smp <= link_out;
    end

    // consumer, byte taken on every edge from the start cycle on
    always @(posedge rst) begin
        if (clk) begin
            start_out <= 1'b0;
            receiving = 1'b0;
            wait_cnt  = 0;
        end else if (start_out) begin
            rx_pkt    = {24'h0, link_smp.db};               // first byte is the header
            rx_len    = 1;
            receiving = 1'b1;
            wait_cnt  = 0;
            start_out <= 1'b0;                              // one cycle only
        end else if (receiving) begin
            if (rx_len < PACKET_BYTES) begin
                rx_pkt[8*rx_len +: 8] = link_smp.db;
            end
            rx_len = rx_len + 1;
            if (!link_smp.rq) begin                         // last byte
                receiving = 1'b0;
                if (rx_len != PACKET_BYTES) begin
                    errors = errors + 1;
                    $display("FAILED %s: packet length expected %0d actual %0d",
                             cur_test, PACKET_BYTES, rx_len);
                end else begin
                    rx_q.push_back(rx_pkt);
                end
            end
        end else if (link_smp.rq && !hold_start) begin
            if (wait_cnt >= start_delay) begin
                start_out <= 1'b1;
            end else begin
                wait_cnt = wait_cnt + 1;
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                         // one step per bit
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic check_byte(input string what, input status_byte_t exp, input status_byte_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input status_word_t exp, input status_word_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_chan(input string what, input chan_id_t exp, input chan_id_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_seq(input string what, input seq_t exp, input seq_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks = checks + 1;
        if (act != exp) begin
            errors = errors + 1;
            $display("FAILED %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (errors == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // new words for the masked channels, one-cycle send pulse
    task automatic send_random(input logic [NUM_CHANNELS-1:0] mask);
        logic [31:0] bits;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (mask[ch]) begin
                draw_bits(24, bits);
                last_word[ch] = bits[23:0];
                if (sent_cnt[ch] < LOG_DEPTH) begin
                    sent_words[ch][sent_cnt[ch]] = bits[23:0];
                    sent_cnt[ch] = sent_cnt[ch] + 1;
                end
            end
        end
        @(posedge rst);
        send <= mask;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (mask[ch]) begin
                status[ch] <= last_word[ch];
            end
        end
        @(posedge rst);
        send <= '0;
    endtask

    task automatic wait_packets(input int n, input int budget);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < budget) begin
            @(negedge rst);
            cyc = cyc + 1;
        end
        if (rx_q.size() < n) begin
            errors = errors + 1;
            $display("ERROR %s: only %0d of %0d packets arrived within %0d cycles",
                     cur_test, rx_q.size(), n, budget);
        end
    endtask

    task automatic wait_quiet(input int quiet, input int budget);
        int calm;
        int cyc;
        calm = 0;
        cyc  = 0;
        while (calm < quiet && cyc < budget) begin
            @(negedge rst);
            cyc = cyc + 1;
            if (link_out.rq || receiving || start_out) begin
                calm = 0;
            end else begin
                calm = calm + 1;
            end
        end
        if (calm < quiet) begin
            errors = errors + 1;
            $display("ERROR %s: status link still busy after %0d cycles", cur_test, budget);
        end
    endtask

    // sequence and newest word of the packet's channel
    task automatic check_packet(input logic [31:0] pkt);
        chan_id_t ch;
        ch = pkt[7:6];
        check_seq("sequence", exp_seq[ch], pkt[5:0]);
        check_word("status word", last_word[ch], pkt[31:8]);
        exp_seq[ch] = seq_t'(exp_seq[ch] + 6'd1);
    endtask

    task automatic test_idle();
        begin_test("idle after reset");
        for (int i = 0; i < BUDGET_IDLE - 10; i++) begin
            @(negedge rst);
            check_flag("rq", 1'b0, link_out.rq);
        end
        check_count("packets", 0, rx_q.size());
        end_test();
    endtask

    task automatic test_single();
        logic [31:0] pkt;
        begin_test("single send per channel");
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            start_delay <= ch;                              // vary the answer time
            send_random(NUM_CHANNELS'(1 << ch));
            wait_packets(1, BUDGET_SINGLE / NUM_CHANNELS - 10);
            if (rx_q.size() > 0) begin
                pkt = rx_q.pop_front();
                check_chan("channel", chan_id_t'(ch), pkt[7:6]);
                check_byte("header", {chan_id_t'(ch), exp_seq[ch]}, pkt[7:0]);
                check_packet(pkt);
            end
        end
        end_test();
    endtask

    task automatic test_all_four();
        logic [31:0] pkt;
        int          seen [NUM_CHANNELS];
        begin_test("all channels at once");
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            seen[ch] = 0;
        end
        start_delay <= 1;
        send_random('1);
        wait_packets(NUM_CHANNELS, BUDGET_ALL / 2);
        wait_quiet(20, BUDGET_ALL / 2 - 10);               // no extra packets behind
        check_count("packets", NUM_CHANNELS, rx_q.size());
        while (rx_q.size() > 0) begin
            pkt = rx_q.pop_front();
            seen[pkt[7:6]] = seen[pkt[7:6]] + 1;
            check_packet(pkt);
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_count("packets on one channel", 1, seen[ch]);
        end
        end_test();
    endtask

    task automatic test_round_robin();
        logic [31:0] pkt;
        chan_id_t    prev;
        logic        first;
        begin_test("round robin on siblings");
        start_delay <= 2;
        first = 1'b1;
        prev  = '0;
        for (int r = 0; r < 6; r++) begin
            send_random(4'b0011);                           // channels 0 and 1, router_a
            wait_packets(2, BUDGET_RR / 6 - 10);
            while (rx_q.size() > 0) begin
                pkt = rx_q.pop_front();
                if (!first) begin
                    check_chan("alternating channel", {1'b0, ~prev[0]}, pkt[7:6]);
                end
                prev  = pkt[7:6];
                first = 1'b0;
                check_packet(pkt);
            end
        end
        end_test();
    endtask

    task automatic test_backpressure();
        logic [31:0]  pkt;
        logic [31:0]  bits;
        chan_id_t     ch;
        int           idx;
        logic         found;
        int           match_idx [NUM_CHANNELS];
        int           got [NUM_CHANNELS];
        status_word_t last_rx [NUM_CHANNELS];
        begin_test("back-pressure");
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            sent_cnt[c]  = 0;
            match_idx[c] = 0;
            got[c]       = 0;
            last_rx[c]   = '0;
        end
        @(posedge rst);
        hold_start  <= 1'b1;
        start_delay <= 0;
        for (int r = 0; r < 5; r++) begin                   // 5 x 12 cycles
            draw_bits(4, bits);
            send_random((r == 4) ? 4'hf : bits[3:0]);
            repeat (10) @(posedge rst);
        end
        repeat (39) @(posedge rst);
        @(negedge rst);
        check_flag("rq while held", 1'b1, link_out.rq);
        @(posedge rst);
        hold_start <= 1'b0;                                 // 100 cycles held
        wait_quiet(30, BUDGET_BP - 120);
        while (rx_q.size() > 0) begin
            pkt = rx_q.pop_front();
            ch  = pkt[7:6];
            check_seq("consecutive sequence", exp_seq[ch], pkt[5:0]);
            exp_seq[ch] = seq_t'(exp_seq[ch] + 6'd1);
            found = 1'b0;
            idx   = match_idx[ch];
            while (!found && idx < sent_cnt[ch]) begin     // later sends only
                if (sent_words[ch][idx] == pkt[31:8]) begin
                    found = 1'b1;
                end else begin
                    idx = idx + 1;
                end
            end
            checks = checks + 1;
            if (found) begin
                match_idx[ch] = idx + 1;
            end else begin
                errors = errors + 1;
                $display("ERROR %s: channel %0d delivered word %h, not a newer send",
                         cur_test, ch, pkt[31:8]);
            end
            got[ch]     = got[ch] + 1;
            last_rx[ch] = pkt[31:8];
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (sent_cnt[c] > 0 && got[c] == 0) begin
                errors = errors + 1;
                $display("ERROR %s: channel %0d delivered nothing", cur_test, c);
            end else if (sent_cnt[c] > 0) begin
                check_word("last value", sent_words[c][sent_cnt[c]-1], last_rx[c]);
            end
        end
        end_test();
    endtask

    initial begin
        send        = '0;
        hold_start  = 1'b0;
        start_delay = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            status[ch]    = '0;
            last_word[ch] = '0;
            exp_seq[ch]   = '0;
            sent_cnt[ch]  = 0;
        end
        repeat (RESET_CYCLES) @(posedge rst);
        clk <= 1'b0;                                        // release reset
        test_idle();
        test_single();
        test_all_four();
        test_round_robin();
        test_backpressure();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog, sum of the test budgets
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, cur_test);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/status_pkg.sv
verilog/status_fifo.sv
verilog/status_router2.sv
verilog/status_generator.sv
verilog/status_top.sv
bench/status_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=status_top_sim

verilator --binary --timing -Wno-fatal -f flist.f --top-module status_top_tb \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "result: fail"
    exit 1
fi
echo "result: pass"
exit 0
